// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cpuSystemTb
FILELIST  = cpu8.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== aluUnit.sv ====
`timescale 1ns/1ns

module aluUnit (
    input  logic [7:0]     dataA,
    input  logic [7:0]     dataB,
    input  cpu8Pkg::aluOpT mode,
    input  logic           carryIn,
    output logic [7:0]     result,
    output logic           carryOut,
    output logic           zeroOut,
    output logic           negativeOut
);
    import cpu8Pkg::*;

    always_comb begin
        result   = dataB;
        carryOut = 1'b0;
        case (mode)
            aluAdd: begin
                {carryOut, result} = {1'b0, dataA} + {1'b0, dataB};
            end
            aluAddCarry: begin
                {carryOut, result} = {1'b0, dataA} + {1'b0, dataB} + {8'd0, carryIn};
            end
            aluSub: begin
                // Carry set means no borrow
                {carryOut, result} = {1'b0, dataA} + {1'b0, ~dataB} + 9'd1;
            end
            aluAnd: result = dataA & dataB;
            aluOr:  result = dataA | dataB;
            aluXor: result = dataA ^ dataB;
            aluShiftLeft: begin
                result   = {dataA[dataWidth-2:0], 1'b0};
                carryOut = dataA[dataWidth-1];   // Bit shifted out
            end
            aluShiftRight: begin
                result   = {1'b0, dataA[dataWidth-1:1]};
                carryOut = dataA[0];
            end
            default: begin
                result   = dataB;   // Pass
                carryOut = 1'b0;
            end
        endcase
    end

    assign zeroOut     = (result == '0);
    assign negativeOut = result[dataWidth-1];

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit (
    input  logic                clk,
    input  logic                reset,
    input  cpu8Pkg::opcodeT     opcode,
    input  logic                zeroFlag,
    input  logic                carryFlag,
    output logic                instFetch,
    output logic                instCapture,
    output logic                targetFetch,
    output logic                regWriteEn,
    output logic                flagWriteEn,
    output logic                pcWriteEn,
    output logic                dataReadEn,
    output logic                dataWriteEn,
    output logic                outStrobe,
    output logic                halted,
    output cpu8Pkg::regSrcT     regSrc,
    output cpu8Pkg::aluBSrcT    aluBSrc,
    output cpu8Pkg::aluOpT      aluMode,
    output cpu8Pkg::dAddrSrcT   dAddrSrc,
    output cpu8Pkg::pcSrcT      pcSrc
);
    import cpu8Pkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    logic      isJump;
    logic      jumpTaken;

    assign isJump = (opcode == opJmp) || (opcode == opJz) || (opcode == opJc);

    always_comb begin
        case (opcode)
            opJmp:   jumpTaken = 1'b1;
            opJz:    jumpTaken = zeroFlag;
            opJc:    jumpTaken = carryFlag;
            default: jumpTaken = 1'b0;
        endcase
    end

    // Opcode to ALU function
    always_comb begin
        case (opcode)
            opAdd:   aluMode = aluAdd;
            opAdc:   aluMode = aluAddCarry;
            opSub:   aluMode = aluSub;
            opAnd:   aluMode = aluAnd;
            opOr:    aluMode = aluOr;
            opXor:   aluMode = aluXor;
            opShl:   aluMode = aluShiftLeft;
            opShr:   aluMode = aluShiftRight;
            default: aluMode = aluPass;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch;
        end else begin
            state <= nextState;
        end
    end

    //**************************************************************************
    // Per-state control outputs and next state
    always_comb begin
        instFetch   = 1'b0;
        instCapture = 1'b0;
        targetFetch = 1'b0;
        regWriteEn  = 1'b0;
        flagWriteEn = 1'b0;
        pcWriteEn   = 1'b0;
        dataReadEn  = 1'b0;
        dataWriteEn = 1'b0;
        outStrobe   = 1'b0;
        regSrc      = regSrcAlu;
        aluBSrc     = bSrcReg;
        dAddrSrc    = dAddrPair;
        pcSrc       = pcIncrement;
        nextState   = state;
        case (state)
            stFetch: begin
                instFetch = 1'b1;
                pcWriteEn = 1'b1;   // PC moves past the instruction word
                nextState = stDecode;
            end
            stDecode: begin
                instCapture = 1'b1;
                if (isJump) begin
                    // Read the target word and step over it
                    instFetch = 1'b1;
                    pcWriteEn = 1'b1;
                    nextState = stJumpFetch;
                end else begin
                    nextState = stExecute;
                end
            end
            stJumpFetch: begin
                targetFetch = 1'b1;
                nextState   = stExecute;
            end
            stExecute: begin
                nextState = stFetch;
                case (opcode)
                    opLdi: begin
                        regWriteEn = 1'b1;
                        regSrc     = regSrcImm;
                    end
                    opAdd, opAdc, opSub, opAnd, opOr, opXor, opShl, opShr: begin
                        regWriteEn  = 1'b1;
                        flagWriteEn = 1'b1;
                    end
                    opLd: begin
                        dataReadEn = 1'b1;
                        nextState  = stMemWait;
                    end
                    opSt: dataWriteEn = 1'b1;
                    opOut: begin
                        dataWriteEn = 1'b1;
                        dAddrSrc    = dAddrIoPage;
                        outStrobe   = 1'b1;
                    end
                    opJmp, opJz, opJc: begin
                        pcWriteEn = jumpTaken;   // Untaken leaves PC past target
                        pcSrc     = pcJump;
                    end
                    opHalt: nextState = stHalted;
                    default: nextState = stFetch;
                endcase
            end
            stMemWait: begin
                regWriteEn = 1'b1;
                regSrc     = regSrcMem;
                nextState  = stFetch;
            end
            stHalted: nextState = stHalted;   // Only reset leaves
            default: nextState = stFetch;
        endcase
    end

    assign halted = (state == stHalted);

    readWriteExclusive: assert property (
        @(posedge clk) disable iff (reset) !(dataReadEn && dataWriteEn)
    );

endmodule

// ==== cpu8.f ====
cpu8Pkg.sv
memBus.sv
aluUnit.sv
registerFile.sv
controlUnit.sv
cpuCore.sv
programMemory.sv
dataMemory.sv
cpuSystem.sv
cpuSystemTb.sv

// ==== cpu8Pkg.sv ====
package cpu8Pkg;

    // Widths and sizes
    localparam int dataWidth = 8;
    localparam int addrWidth = 16;
    localparam int instWidth = 16;
    localparam int regCount  = 16;
    localparam int progDepth = 256;   // Instruction words
    localparam int dataDepth = 256;   // RAM bytes

    // High address byte of the output port page
    localparam logic [7:0] ioPageHigh = 8'h10;

    typedef enum logic [3:0] {
        opLdi  = 4'h0,
        opAdd  = 4'h1,
        opAdc  = 4'h2,
        opSub  = 4'h3,
        opAnd  = 4'h4,
        opOr   = 4'h5,
        opXor  = 4'h6,
        opShl  = 4'h7,
        opShr  = 4'h8,
        opLd   = 4'h9,
        opSt   = 4'hA,
        opOut  = 4'hB,
        opJmp  = 4'hC,
        opJz   = 4'hD,
        opJc   = 4'hE,
        opHalt = 4'hF
    } opcodeT;

    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stExecute,
        stMemWait,
        stJumpFetch,
        stHalted
    } ctrlStateT;

    typedef enum logic [3:0] {
        aluPass,
        aluAdd,
        aluAddCarry,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluShiftLeft,
        aluShiftRight
    } aluOpT;

    // Datapath mux selects
    typedef enum logic [1:0] {regSrcAlu, regSrcImm, regSrcMem} regSrcT;
    typedef enum logic {bSrcReg, bSrcImm} aluBSrcT;
    typedef enum logic {dAddrPair, dAddrIoPage} dAddrSrcT;
    typedef enum logic {pcIncrement, pcJump} pcSrcT;

endpackage

// ==== cpuCore.sv ====
`timescale 1ns/1ns

module cpuCore (
    input  logic  clk,
    input  logic  reset,
    memBus.master instBus,
    memBus.master dataBus,
    output logic  outStrobe,
    output logic  halted
);
    import cpu8Pkg::*;

    logic [addrWidth-1:0] pc;
    logic [addrWidth-1:0] nextPc;
    logic [addrWidth-1:0] jumpTarget;
    logic [instWidth-1:0] instReg;
    logic [2:0]           statusReg;   // {negative, zero, carry}
    logic [dataWidth-1:0] immediate;
    opcodeT               curOpcode;

    // Control wires
    logic     instFetch;
    logic     instCapture;
    logic     targetFetch;
    logic     regWriteEn;
    logic     flagWriteEn;
    logic     pcWriteEn;
    regSrcT   regSrc;
    aluBSrcT  aluBSrc;
    aluOpT    aluMode;
    dAddrSrcT dAddrSrc;
    pcSrcT    pcSrc;

    // Register file and ALU wires
    logic [dataWidth-1:0] regWriteData;
    logic [dataWidth-1:0] outA;
    logic [dataWidth-1:0] outB;
    logic [dataWidth-1:0] pairLow;
    logic [dataWidth-1:0] pairHigh;
    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] aluResult;
    logic                 aluCarry;
    logic                 aluZero;
    logic                 aluNegative;

    assign immediate = instReg[11:4];

    // Decode sees the word on the bus before it lands in instReg
    assign curOpcode = opcodeT'(instCapture ? instBus.readData[3:0] : instReg[3:0]);

    controlUnit control (
        .clk         (clk),
        .reset       (reset),
        .opcode      (curOpcode),
        .zeroFlag    (statusReg[1]),
        .carryFlag   (statusReg[0]),
        .instFetch   (instFetch),
        .instCapture (instCapture),
        .targetFetch (targetFetch),
        .regWriteEn  (regWriteEn),
        .flagWriteEn (flagWriteEn),
        .pcWriteEn   (pcWriteEn),
        .dataReadEn  (dataBus.readEn),
        .dataWriteEn (dataBus.writeEn),
        .outStrobe   (outStrobe),
        .halted      (halted),
        .regSrc      (regSrc),
        .aluBSrc     (aluBSrc),
        .aluMode     (aluMode),
        .dAddrSrc    (dAddrSrc),
        .pcSrc       (pcSrc)
    );

    //**************************************************************************
    // Register file and its write source
    always_comb begin
        case (regSrc)
            regSrcImm: regWriteData = immediate;
            regSrcMem: regWriteData = dataBus.readData;
            default:   regWriteData = aluResult;
        endcase
    end

    registerFile regFile (
        .clk       (clk),
        .reset     (reset),
        .selectA   (instReg[15:12]),
        .selectB   (instReg[11:8]),
        .writeData (regWriteData),
        .writeEn   (regWriteEn),
        .outA      (outA),
        .outB      (outB),
        .pairLow   (pairLow),
        .pairHigh  (pairHigh)
    );

    //**************************************************************************
    // ALU and status register
    assign aluB = (aluBSrc == bSrcImm) ? immediate : outB;

    aluUnit alu (
        .dataA       (outA),
        .dataB       (aluB),
        .mode        (aluMode),
        .carryIn     (statusReg[0]),
        .result      (aluResult),
        .carryOut    (aluCarry),
        .zeroOut     (aluZero),
        .negativeOut (aluNegative)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            statusReg <= '0;
        end else if (flagWriteEn) begin
            statusReg <= {aluNegative, aluZero, aluCarry};
        end
    end

    //**************************************************************************
    // Memory buses
    assign dataBus.address   = (dAddrSrc == dAddrIoPage) ? {ioPageHigh, immediate}
                                                         : {pairHigh, pairLow};
    assign dataBus.writeData = outA;   // ST and OUT both store register A

    assign instBus.address   = pc;
    assign instBus.readEn    = instFetch && !reset;   // Idle while held in reset
    assign instBus.writeData = '0;     // Program store is read-only here
    assign instBus.writeEn   = 1'b0;

    //**************************************************************************
    // PC, instruction and jump-target registers
    assign nextPc = (pcSrc == pcJump) ? jumpTarget : pc + 16'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (pcWriteEn) begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (instCapture) instReg <= instBus.readData;
        if (targetFetch) jumpTarget <= instBus.readData;
    end

    noPcMoveWhenHalted: assert property (
        @(posedge clk) disable iff (reset) halted |-> !pcWriteEn
    );

endmodule

// ==== cpuSystem.sv ====
`timescale 1ns/1ns

module cpuSystem (
    input  logic        clk,
    input  logic        reset,
    input  logic        loadEn,
    input  logic [7:0]  loadAddress,
    input  logic [15:0] loadData,
    output logic        outValid,
    output logic [7:0]  outAddress,
    output logic [7:0]  outData,
    output logic        halted
);
    import cpu8Pkg::*;

    logic outStrobe;

    memBus #(.readWidth(instWidth)) instBus ();
    memBus #(.readWidth(dataWidth)) dataBus ();

    cpuCore core (
        .clk       (clk),
        .reset     (reset),
        .instBus   (instBus.master),
        .dataBus   (dataBus.master),
        .outStrobe (outStrobe),
        .halted    (halted)
    );

    programMemory progMem (
        .clk         (clk),
        .loadEn      (loadEn),
        .loadAddress (loadAddress),
        .loadData    (loadData),
        .bus         (instBus.slave)
    );

    dataMemory dataMem (
        .clk        (clk),
        .reset      (reset),
        .bus        (dataBus.slave),
        .outValid   (outValid),
        .outAddress (outAddress),
        .outData    (outData)
    );

    // Every OUT from the core reaches the port on the next cycle
    outReachesPort: assert property (
        @(posedge clk) disable iff (reset) outStrobe |=> outValid
    );

endmodule

// ==== cpuSystemTb.sv ====
`timescale 1ns/1ns

module cpuSystemTb;
    import cpu8Pkg::*;

    logic        clk;
    logic        reset;
    logic        loadEn;
    logic [7:0]  loadAddress;
    logic [15:0] loadData;
    logic        outValid;
    logic [7:0]  outAddress;
    logic [7:0]  outData;
    logic        halted;

    logic [15:0] prog [progDepth];
    int          progLen;
    int          instCount;
    logic [31:0] lcgState;
    logic [7:0]  modelRegs [regCount];
    logic [7:0]  modelRam [dataDepth];
    logic [7:0]  expAddr [$];   // Expected OUT events in order
    logic [7:0]  expData [$];
    int          expCycles;
    int          valueErrors;
    int          protocolErrors;

    cpuSystem dut (
        .clk         (clk),
        .reset       (reset),
        .loadEn      (loadEn),
        .loadAddress (loadAddress),
        .loadData    (loadData),
        .outValid    (outValid),
        .outAddress  (outAddress),
        .outData     (outData),
        .halted      (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Upper LCG bits since the low bits cycle too fast
    function automatic int pickBelow(int limit);
        logic [31:0] r;
        r = nextRandom();
        return int'(r[31:16]) % limit;
    endfunction

    //**************************************************************************
    // Program generator
    task automatic emit(input logic [3:0] regA, input logic [7:0] imm, input opcodeT op);
        prog[8'(progLen)] = {regA, imm, op};
        progLen++;
        instCount++;
    endtask

    task automatic addOut(input logic [3:0] r);
        emit(r, 8'(pickBelow(256)), opOut);
    endtask

    task automatic generateProgram();
        int         kind;
        int         skip;
        int         patchAt;
        logic [3:0] ra;
        logic [3:0] rb;
        opcodeT     op;
        progLen   = 0;
        instCount = 0;
        while (instCount < 56) begin
            kind = pickBelow(6);
            ra   = 4'(pickBelow(14));                            // r14/r15 kept as pointer
            rb   = (pickBelow(2) == 0) ? ra : 4'(pickBelow(14));
            case (kind)
                0: begin
                    emit(ra, 8'(pickBelow(256)), opLdi);
                    addOut(ra);
                end
                1: begin
                    emit(ra, {rb, 4'h0}, opcodeT'(4'(1 + pickBelow(8))));
                    addOut(ra);
                end
                2: begin
                    // Store, then load the same byte into a different register
                    rb = 4'((int'(ra) + 1 + pickBelow(13)) % 14);
                    emit(4'd15, 8'h00, opLdi);
                    emit(4'd14, 8'(pickBelow(256)), opLdi);
                    emit(ra, 8'hE0, opSt);
                    emit(rb, 8'hE0, opLd);
                    addOut(rb);
                end
                3: begin
                    emit(4'd15, ioPageHigh, opLdi);   // Pointer into the port page
                    emit(4'd14, 8'(pickBelow(256)), opLdi);
                    emit(ra, 8'hE0, opLd);
                    addOut(ra);
                    emit(4'd15, 8'h00, opLdi);
                end
                default: begin
                    if (kind == 4) begin
                        emit(ra, {rb, 4'h0}, opcodeT'(4'(1 + pickBelow(8))));   // Sets flags
                        addOut(ra);
                        op = (pickBelow(2) == 0) ? opJz : opJc;
                    end else begin
                        op = opJmp;
                    end
                    emit(4'd0, 8'h00, op);
                    patchAt = progLen;
                    prog[8'(progLen)] = 16'h0000;
                    progLen++;
                    skip = 1 + pickBelow(2);
                    for (int i = 0; i < skip; i++) begin
                        ra = 4'(pickBelow(14));
                        emit(ra, 8'(pickBelow(256)), opLdi);
                        addOut(ra);
                    end
                    prog[8'(patchAt)] = 16'(progLen);   // Forward target
                end
            endcase
        end
        emit(4'd0, 8'h00, opHalt);
    endtask

    //**************************************************************************
    // Instruction-set model
    function automatic logic [8:0] aluModel(input logic [3:0] op, input logic [7:0] a,
                                            input logic [7:0] b, input logic cin);
        logic [8:0] r;
        case (op)
            opAdd:   r = {1'b0, a} + {1'b0, b};
            opAdc:   r = {1'b0, a} + {1'b0, b} + {8'd0, cin};
            opSub:   r = {(a >= b), a - b};   // Carry means no borrow
            opAnd:   r = {1'b0, a & b};
            opOr:    r = {1'b0, a | b};
            opXor:   r = {1'b0, a ^ b};
            opShl:   r = {a, 1'b0};
            opShr:   r = {a[0], 1'b0, a[7:1]};
            default: r = {1'b0, b};
        endcase
        return r;
    endfunction

    task automatic runModel();
        logic [7:0]  pc;
        logic [15:0] word;
        logic [3:0]  ra;
        logic [3:0]  pairBase;
        logic [7:0]  imm;
        logic [7:0]  pairHi;
        logic [7:0]  pairLo;
        logic [8:0]  res;
        logic        carry;
        logic        zero;
        logic        taken;
        bit          done;
        int          steps;
        pc        = 8'd0;
        carry     = 1'b0;
        zero      = 1'b0;
        done      = 1'b0;
        steps     = 0;
        expCycles = 0;
        modelRegs = '{default: 8'h00};
        modelRam  = '{default: 8'h00};
        while (!done && steps < 1000) begin
            word     = prog[pc];
            pc       = pc + 8'd1;
            ra       = word[15:12];
            imm      = word[11:4];
            pairBase = {word[11:9], 1'b0};
            pairLo   = modelRegs[pairBase];
            pairHi   = modelRegs[pairBase | 4'd1];
            steps++;
            case (word[3:0])
                opLdi: begin
                    modelRegs[ra] = imm;
                    expCycles += 3;
                end
                opLd: begin
                    modelRegs[ra] = (pairHi == ioPageHigh) ? 8'h00 : modelRam[pairLo];
                    expCycles += 4;
                end
                opSt: begin
                    if (pairHi == ioPageHigh) begin
                        expAddr.push_back(pairLo);
                        expData.push_back(modelRegs[ra]);
                    end else begin
                        modelRam[pairLo] = modelRegs[ra];
                    end
                    expCycles += 3;
                end
                opOut: begin
                    expAddr.push_back(imm);
                    expData.push_back(modelRegs[ra]);
                    expCycles += 3;
                end
                opJmp, opJz, opJc: begin
                    taken = (word[3:0] == opJmp) || ((word[3:0] == opJz) && zero)
                            || ((word[3:0] == opJc) && carry);
                    pc = taken ? prog[pc][7:0] : pc + 8'd1;   // Untaken skips target word
                    expCycles += 4;
                end
                opHalt: begin
                    done = 1'b1;
                    expCycles += 3;
                end
                default: begin
                    res           = aluModel(word[3:0], modelRegs[ra], modelRegs[word[11:8]],
                                             carry);
                    modelRegs[ra] = res[7:0];
                    carry         = res[8];
                    zero          = (res[7:0] == 8'h00);
                    expCycles += 3;
                end
            endcase
        end
    endtask

    //**************************************************************************
    // Output port checks
    task automatic checkOutput();
        logic [7:0] wantAddr;
        logic [7:0] wantData;
        if (outValid) begin
            assert (expAddr.size() != 0) else begin
                $display("OUT event at port 0x%0h arrived after the model ran out of events",
                         outAddress);
                protocolErrors++;
            end
            if (expAddr.size() != 0) begin
                wantAddr = expAddr.pop_front();
                wantData = expData.pop_front();
                assert (outAddress == wantAddr) else begin
                    $display("[ERROR] outAddress got 0x%0h expected 0x%0h", outAddress, wantAddr);
                    valueErrors++;
                end
                assert (outData == wantData) else begin
                    $display("[ERROR] outData got 0x%0h expected 0x%0h", outData, wantData);
                    valueErrors++;
                end
            end
        end
    endtask

    initial begin
        int holdCycles;
        int cycle;
        int limit;
        int haltCycle;
        reset          = 1'b1;
        loadEn         = 1'b0;
        loadAddress    = 8'h00;
        loadData       = 16'h0000;
        lcgState       = 32'd19167;
        valueErrors    = 0;
        protocolErrors = 0;
        generateProgram();
        runModel();
        $display("Program of %0d words, %0d OUT events, halt expected at cycle %0d",
                 progLen, expAddr.size(), expCycles);

        // Load the program while reset is held
        holdCycles = (progLen + 1 > 5) ? progLen + 1 : 5;
        for (int i = 0; i < holdCycles; i++) begin
            @(posedge clk);
            if (i < progLen) begin
                loadEn      <= 1'b1;
                loadAddress <= 8'(i);
                loadData    <= prog[8'(i)];
            end else begin
                loadEn <= 1'b0;
            end
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!outValid && !halted) else begin
            $display("[ERROR] after reset outValid 0x%0h halted 0x%0h, expected 0x0 0x0",
                     outValid, halted);
            valueErrors++;
        end

        cycle     = 0;
        haltCycle = -1;
        limit     = expCycles + 200;
        while (haltCycle < 0 && cycle < limit) begin
            @(posedge clk);
            cycle++;
            @(negedge clk);
            checkOutput();
            if (halted) haltCycle = cycle;
        end

        if (haltCycle < 0) begin
            $display("Timeout: the CPU did not halt within %0d cycles", limit);
            protocolErrors++;
        end else begin
            assert (haltCycle == expCycles) else begin
                $display("[ERROR] halted rose at cycle 0x%0h expected 0x%0h",
                         haltCycle, expCycles);
                valueErrors++;
            end
        end

        // Quiet after halt
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            assert (!outValid) else begin
                $display("OUT event appeared after the CPU halted");
                protocolErrors++;
            end
        end
        assert (expAddr.size() == 0) else begin
            $display("%0d expected OUT events never appeared", expAddr.size());
            protocolErrors++;
        end

        $display("Error counts: value %0d, protocol %0d", valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== dataMemory.sv ====
`timescale 1ns/1ns

module dataMemory (
    input  logic       clk,
    input  logic       reset,
    memBus.slave       bus,
    output logic       outValid,
    output logic [7:0] outAddress,
    output logic [7:0] outData
);
    import cpu8Pkg::*;

    logic [dataWidth-1:0] mem [dataDepth];
    logic                 ioHit;

    assign ioHit = (bus.address[15:8] == ioPageHigh);

    always_ff @(posedge clk) begin
        if (bus.writeEn && !ioHit) begin
            mem[bus.address[7:0]] <= bus.writeData;
        end
        if (bus.readEn) begin
            bus.readData <= ioHit ? '0 : mem[bus.address[7:0]];   // Port page reads as zero
        end
        if (bus.writeEn && ioHit) begin
            outAddress <= bus.address[7:0];
            outData    <= bus.writeData;
        end
    end

    // One-cycle strobe per port write
    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= bus.writeEn && ioHit;
        end
    end

    outAfterWrite: assert property (
        @(posedge clk) disable iff (reset) outValid |-> $past(bus.writeEn)
    );

endmodule

// ==== memBus.sv ====
`timescale 1ns/1ns

interface memBus #(
    parameter int readWidth = cpu8Pkg::dataWidth
);
    import cpu8Pkg::*;

    logic [addrWidth-1:0] address;
    logic [dataWidth-1:0] writeData;
    logic [readWidth-1:0] readData;   // Valid the cycle after readEn
    logic                 readEn;
    logic                 writeEn;

    modport master (output address, writeData, readEn, writeEn, input readData);
    modport slave (input address, writeData, readEn, writeEn, output readData);

endinterface

// ==== programMemory.sv ====
`timescale 1ns/1ns

module programMemory (
    input  logic        clk,
    input  logic        loadEn,
    input  logic [7:0]  loadAddress,
    input  logic [15:0] loadData,
    memBus.slave        bus
);
    import cpu8Pkg::*;

    logic [instWidth-1:0] mem [progDepth];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddress] <= loadData;   // Loaded while the core sits in reset
        end
        if (bus.readEn) begin
            bus.readData <= mem[bus.address[7:0]];
        end
    end

endmodule

// ==== registerFile.sv ====
`timescale 1ns/1ns

module registerFile (
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] selectA,
    input  logic [3:0] selectB,
    input  logic [7:0] writeData,
    input  logic       writeEn,
    output logic [7:0] outA,
    output logic [7:0] outB,
    output logic [7:0] pairLow,
    output logic [7:0] pairHigh
);
    import cpu8Pkg::*;

    logic [dataWidth-1:0] regs [regCount];

    assign outA = regs[selectA];
    assign outB = regs[selectB];

    // Even/odd pair named by selectB without its low bit
    assign pairLow  = regs[{selectB[3:1], 1'b0}];
    assign pairHigh = regs[{selectB[3:1], 1'b1}];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[selectA] <= writeData;   // Register A is the destination
        end
    end

endmodule
